// ==== design/cache_biu_defs.svh ====
/* fixed line geometry of the data cache bus controller
   changing CB_BURST_LEN also needs a matching burst type on the BIU */
`ifndef CACHE_BIU_DEFS_SVH
`define CACHE_BIU_DEFS_SVH

////////////////////
// widths
////////////////////
`define CB_XLEN 32          // data word
`define CB_PLEN 32          // physical byte address

////////////////////
// line and burst
////////////////////
`define CB_BURST_LEN 4      // words per line, one WRAP4 burst

// outstanding beats, a burst plus a few single transfers
`define CB_INFLIGHT_BITS 3

`endif

// ==== design/cache_biu_pkg.sv ====
/* types shared by the controller blocks and the testbench
   widths come from the defines header */
`include "cache_biu_defs.svh"

package cache_biu_pkg;

  typedef logic [`CB_XLEN-1:0]              word_t;      // one data word
  typedef logic [`CB_PLEN-1:0]              addr_t;      // byte address
  typedef logic [`CB_XLEN/8-1:0]            be_t;        // byte enables
  typedef logic [`CB_BURST_LEN*`CB_XLEN-1:0] line_t;     // full cache line
  typedef logic [$clog2(`CB_BURST_LEN)-1:0] beat_idx_t;  // word within line
  typedef logic [`CB_BURST_LEN-1:0]         beat_mask_t; // one bit per word
  typedef logic [`CB_INFLIGHT_BITS-1:0]     inflight_t;  // outstanding beats

  // request from the memory FSM
  typedef enum logic [1:0] {
    CMD_NOP,
    CMD_READWAY,
    CMD_WRITEWAY
  } biucmd_e;

  // burst controller state
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT4BIU,
    ST_BURST
  } biufsm_e;

  typedef enum logic {
    BT_INCR,   // single word
    BT_WRAP4   // line burst, wraps at the line boundary
  } burst_type_e;

endpackage

// ==== design/biu_burst_fsm.sv ====
/* burst FSM with one line burst at a time
   non-cacheable strobes only go out with CMD_NOP in idle
   request fields stay frozen while the strobe waits for biu_stb_ack_i */
`timescale 1ns/1ps
`include "cache_biu_defs.svh"

module biu_burst_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  cache_biu_pkg::biucmd_e     biucmd_i,
  input  logic                       nc_req_i,
  input  cache_biu_pkg::addr_t       adr_i,
  input  logic                       we_i,
  input  cache_biu_pkg::word_t       d_i,
  input  cache_biu_pkg::addr_t       evict_adr_i,
  input  cache_biu_pkg::word_t       first_wr_word_i,  // evict word 0
  input  cache_biu_pkg::word_t       burst_wr_word_i,  // shifted buffer word
  input  logic                       biu_stb_ack_i,
  input  logic                       biu_ack_i,
  input  logic                       biu_err_i,
  output cache_biu_pkg::biufsm_e     state_o,
  output logic                       biucmd_ack_o,
  output logic                       biucmd_busy_o,
  output logic                       biu_stb_o,
  output cache_biu_pkg::addr_t       biu_adr_o,
  output logic                       biu_we_o,
  output cache_biu_pkg::word_t       biu_d_o,
  output cache_biu_pkg::burst_type_e biu_type_o
);
  import cache_biu_pkg::*;

  localparam int WORD_LSB = $clog2(`CB_XLEN/8);

  biufsm_e   state_q;
  beat_idx_t burst_cnt_q;  // beats left minus one
  logic      last_beat;
  addr_t     adr_hold_q;   // stretched strobe fields
  logic      we_hold_q;
  word_t     d_hold_q;

  assign state_o   = state_q;
  assign last_beat = biu_err_i | (biu_ack_i & (burst_cnt_q == '0));  // error ends burst early

  ////////////////////
  // state and busy
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q       <= ST_IDLE;
      biucmd_busy_o <= 1'b0;
      burst_cnt_q   <= '1;
    end
    else
    begin
      unique case (state_q)
        ST_IDLE:
        begin
          burst_cnt_q <= '1;
          if (biucmd_i != CMD_NOP)
          begin
            biucmd_busy_o <= 1'b1;
            state_q       <= biu_stb_ack_i ? ST_BURST : ST_WAIT4BIU;  // skip wait if taken now
          end
        end
        ST_WAIT4BIU:
          if (biu_stb_ack_i)
            state_q <= ST_BURST;
        ST_BURST:
        begin
          if (biu_ack_i)
            burst_cnt_q <= burst_cnt_q - 1'b1;
          if (last_beat)
          begin
            state_q       <= ST_IDLE;
            biucmd_busy_o <= 1'b0;
          end
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  assign biucmd_ack_o = (state_q == ST_BURST) & last_beat;

  ////////////////////
  // request mux
  ////////////////////
  always_comb
  begin
    biu_stb_o = 1'b0;
    biu_adr_o = adr_hold_q;
    biu_we_o  = we_hold_q;
    biu_d_o   = d_hold_q;
    unique case (state_q)
      ST_IDLE:
        unique case (biucmd_i)
          CMD_READWAY:
          begin
            biu_stb_o = 1'b1;
            biu_adr_o = {adr_i[`CB_PLEN-1:WORD_LSB], {WORD_LSB{1'b0}}};  // wrap starts here
            biu_we_o  = 1'b0;
            biu_d_o   = '0;
          end
          CMD_WRITEWAY:
          begin
            biu_stb_o = 1'b1;
            biu_adr_o = evict_adr_i;
            biu_we_o  = 1'b1;
            biu_d_o   = first_wr_word_i;  // taken with the strobe
          end
          default:
          begin
            biu_stb_o = nc_req_i;  // single pass-through transfer
            biu_adr_o = adr_i;
            biu_we_o  = we_i;
            biu_d_o   = d_i;
          end
        endcase
      ST_WAIT4BIU:
        biu_stb_o = 1'b1;          // hold strobe and fields from hold regs
      ST_BURST:
        biu_d_o = burst_wr_word_i; // next write word advanced by biu_d_ack_i
      default:
        biu_stb_o = 1'b0;
    endcase
  end

  assign biu_type_o = (state_q == ST_IDLE && biucmd_i == CMD_NOP) ? BT_INCR : BT_WRAP4;

  // capture the request every idle cycle
  always_ff @(posedge clk_i)
  begin
    if (state_q == ST_IDLE)
    begin
      adr_hold_q <= biu_adr_o;
      we_hold_q  <= biu_we_o;
      d_hold_q   <= biu_d_o;
    end
  end

  // memory FSM keeps its command until the burst is acknowledged
  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biucmd_busy_o |-> $stable(biucmd_i));

endmodule

// ==== design/biu_line_buffer.sv ====
/* line buffer shared by fill and writeback
   a pending store is merged into its beat on the fly, by byte enable
   valid bits only track fills and clear in every idle cycle */
`timescale 1ns/1ps
`include "cache_biu_defs.svh"

module biu_line_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  cache_biu_pkg::biufsm_e state_i,
  input  logic                   burst_we_i,       // burst is a writeback
  input  logic                   load_i,           // load evict line in idle
  input  cache_biu_pkg::line_t   evict_line_i,
  input  logic                   req_i,            // lookup qualifier
  input  cache_biu_pkg::addr_t   adr_i,
  input  logic                   we_i,
  input  cache_biu_pkg::be_t     be_i,
  input  cache_biu_pkg::word_t   d_i,
  input  cache_biu_pkg::addr_t   biu_adro_i,
  input  cache_biu_pkg::word_t   biu_q_i,
  input  logic                   biu_ack_i,
  input  logic                   biu_d_ack_i,
  input  cache_biu_pkg::addr_t   hold_adr_i,       // address of the running burst
  output cache_biu_pkg::word_t   first_wr_word_o,
  output cache_biu_pkg::word_t   burst_wr_word_o,
  output logic                   in_linebuf_o,
  output cache_biu_pkg::line_t   biu_line_o,
  output logic                   biu_line_dirty_o
);
  import cache_biu_pkg::*;

  localparam int WORD_LSB = $clog2(`CB_XLEN/8);
  localparam int LINE_LSB = WORD_LSB + $clog2(`CB_BURST_LEN);

  line_t      line_q;
  beat_mask_t valid_q;
  logic       dirty_q;
  beat_idx_t  beat_idx;   // index of the returning beat
  beat_idx_t  req_idx;    // index the cache asks for
  logic       beat_hit;
  logic       fill_beat;
  word_t      beat_q;     // beat after store merge

  // replace enabled bytes of old_w by new_w
  function automatic word_t be_merge(be_t be, word_t old_w, word_t new_w);
    word_t res;
    res = old_w;
    for (int i = 0; i < `CB_XLEN/8; i++)
    begin
      if (be[i])
        res[i*8 +: 8] = new_w[i*8 +: 8];
    end
    return res;
  endfunction

  assign beat_idx  = biu_adro_i[LINE_LSB-1:WORD_LSB];
  assign req_idx   = adr_i[LINE_LSB-1:WORD_LSB];
  assign beat_hit  = biu_adro_i[`CB_PLEN-1:WORD_LSB] == adr_i[`CB_PLEN-1:WORD_LSB];
  assign fill_beat = (state_i == ST_BURST) & ~burst_we_i & biu_ack_i;
  assign beat_q    = (we_i & beat_hit) ? be_merge(be_i, biu_q_i, d_i) : biu_q_i;

  ////////////////////
  // line storage
  ////////////////////
  always_ff @(posedge clk_i)
  begin
    if (state_i == ST_IDLE && load_i)
      line_q <= evict_line_i >> `CB_XLEN;               // word 0 leaves with the strobe
    else if (fill_beat)
      line_q[beat_idx*`CB_XLEN +: `CB_XLEN] <= beat_q;
    else if (state_i == ST_BURST && burst_we_i && biu_d_ack_i)
      line_q <= line_q >> `CB_XLEN;                     // next write word to bit 0
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= 1'b0;
    end
    else if (state_i == ST_IDLE)
    begin
      valid_q <= '0;
      dirty_q <= 1'b0;
    end
    else if (fill_beat)
    begin
      valid_q[beat_idx] <= 1'b1;
      dirty_q           <= dirty_q | (we_i & beat_hit);
    end
  end

  assign first_wr_word_o = evict_line_i[0 +: `CB_XLEN];
  assign burst_wr_word_o = line_q[0 +: `CB_XLEN];

  // word already here in the line of the running burst
  assign in_linebuf_o = req_i
                      & (hold_adr_i[`CB_PLEN-1:LINE_LSB] == adr_i[`CB_PLEN-1:LINE_LSB])
                      & valid_q[req_idx];

  // line to the data memory with current beat overlaid
  always_comb
  begin
    biu_line_o = line_q;
    if (fill_beat)
      biu_line_o[beat_idx*`CB_XLEN +: `CB_XLEN] = beat_q;
  end

  assign biu_line_dirty_o = dirty_q | (fill_beat & we_i & beat_hit);  // current beat included

  // WRAP4 returns each word exactly once
  a_fill_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_beat |-> !valid_q[beat_idx]);

endmodule

// ==== design/biu_inflight_tracker.sv ====
/* counts beats the BIU still owes, a burst counts as four
   after a flush, acks of beats issued before it are swallowed */
`timescale 1ns/1ps
`include "cache_biu_defs.svh"

module biu_inflight_tracker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       biu_stb_ack_i,
  input  cache_biu_pkg::burst_type_e biu_type_i,
  input  logic                       biu_ack_i,
  input  logic                       biu_err_i,
  output cache_biu_pkg::inflight_t   inflight_o,
  output logic                       nc_ack_o
);
  import cache_biu_pkg::*;

  inflight_t discard_q;  // beats still to be dropped
  inflight_t add_beats;
  logic      done;       // one beat retired

  assign done      = biu_ack_i | biu_err_i;
  assign add_beats = !biu_stb_ack_i         ? inflight_t'(0)
                   : (biu_type_i == BT_WRAP4) ? inflight_t'(`CB_BURST_LEN)
                   :                          inflight_t'(1);

  // strobe ack and beat ack may share a cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_o <= '0;
    else
      inflight_o <= inflight_o + add_beats - inflight_t'(done);
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard_q <= '0;
    else if (flush_i)
      discard_q <= (|inflight_o && done) ? inflight_o - 1'b1 : inflight_o;
    else if (|discard_q && done)
      discard_q <= discard_q - 1'b1;
  end

  assign nc_ack_o = biu_ack_i & ~flush_i & ~|discard_q;

  // BIU never acks more beats than were requested
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (done && !biu_stb_ack_i) |-> (inflight_o != '0));

endmodule

// ==== design/cache_biu_ctrl.sv ====
/* bus side of the data cache, between memory FSM and BIU
   word transfers only, line of four words moved as WRAP4 */
`timescale 1ns/1ps

module cache_biu_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // memory FSM side
  input  cache_biu_pkg::biucmd_e     biucmd_i,
  output logic                       biucmd_ack_o,
  output logic                       biucmd_busy_o,
  input  logic                       nc_req_i,
  output logic                       nc_ack_o,
  output cache_biu_pkg::inflight_t   inflight_o,
  input  logic                       flush_i,
  input  cache_biu_pkg::addr_t       adr_i,
  input  logic                       we_i,
  input  cache_biu_pkg::be_t         be_i,
  input  cache_biu_pkg::word_t       d_i,
  input  cache_biu_pkg::addr_t       evict_adr_i,
  input  cache_biu_pkg::line_t       evict_line_i,
  output logic                       in_linebuf_o,
  output cache_biu_pkg::line_t       biu_line_o,
  output logic                       biu_line_dirty_o,

  // BIU side
  output logic                       biu_stb_o,
  input  logic                       biu_stb_ack_i,
  input  logic                       biu_d_ack_i,
  output cache_biu_pkg::addr_t       biu_adr_o,
  input  cache_biu_pkg::addr_t       biu_adro_i,
  output cache_biu_pkg::burst_type_e biu_type_o,
  output logic                       biu_we_o,
  output cache_biu_pkg::word_t       biu_d_o,
  input  cache_biu_pkg::word_t       biu_q_i,
  input  logic                       biu_ack_i,
  input  logic                       biu_err_i
);
  import cache_biu_pkg::*;

  biufsm_e state;
  word_t   first_wr_word;
  word_t   burst_wr_word;

  biu_burst_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .biucmd_i        (biucmd_i),
    .nc_req_i        (nc_req_i),
    .adr_i           (adr_i),
    .we_i            (we_i),
    .d_i             (d_i),
    .evict_adr_i     (evict_adr_i),
    .first_wr_word_i (first_wr_word),
    .burst_wr_word_i (burst_wr_word),
    .biu_stb_ack_i   (biu_stb_ack_i),
    .biu_ack_i       (biu_ack_i),
    .biu_err_i       (biu_err_i),
    .state_o         (state),
    .biucmd_ack_o    (biucmd_ack_o),
    .biucmd_busy_o   (biucmd_busy_o),
    .biu_stb_o       (biu_stb_o),
    .biu_adr_o       (biu_adr_o),
    .biu_we_o        (biu_we_o),
    .biu_d_o         (biu_d_o),
    .biu_type_o      (biu_type_o)
  );

  // we out of the FSM is the writeback flag in idle and in burst
  // busy is high exactly outside idle, so lookups only hit a live fill
  biu_line_buffer u_buf (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .state_i          (state),
    .burst_we_i       (biu_we_o),
    .load_i           (biu_we_o),
    .evict_line_i     (evict_line_i),
    .req_i            (biucmd_busy_o),
    .adr_i            (adr_i),
    .we_i             (we_i),
    .be_i             (be_i),
    .d_i              (d_i),
    .biu_adro_i       (biu_adro_i),
    .biu_q_i          (biu_q_i),
    .biu_ack_i        (biu_ack_i),
    .biu_d_ack_i      (biu_d_ack_i),
    .hold_adr_i       (biu_adr_o),   // frozen outside idle
    .first_wr_word_o  (first_wr_word),
    .burst_wr_word_o  (burst_wr_word),
    .in_linebuf_o     (in_linebuf_o),
    .biu_line_o       (biu_line_o),
    .biu_line_dirty_o (biu_line_dirty_o)
  );

  biu_inflight_tracker u_inflight (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_type_i    (biu_type_o),
    .biu_ack_i     (biu_ack_i),
    .biu_err_i     (biu_err_i),
    .inflight_o    (inflight_o),
    .nc_ack_o      (nc_ack_o)
  );

endmodule

// ==== tests/cache_biu_tb.sv ====
/* testbench for the cache bus controller, the BIU is modelled by tasks
   the model takes each strobe after the table's stall count, beats follow back to back */
`timescale 1ns/1ps
`include "cache_biu_defs.svh"

module cache_biu_tb;
  import cache_biu_pkg::*;

  typedef enum int {T_FILL, T_FILL_STORE, T_WRITEBACK, T_NONCACHE, T_FLUSH} test_kind_e;

  localparam int          NUM_TESTS = 9;
  localparam int          WD_CYCLES = NUM_TESTS * 64 + 32;
  localparam logic [31:0] SEED      = 32'he642;

  logic    clk_i;
  logic    rst_ni;
  biucmd_e biucmd_i;
  logic    nc_req_i, flush_i, we_i;
  addr_t   adr_i, evict_adr_i, biu_adro_i;
  be_t     be_i;
  word_t   d_i, biu_q_i;
  line_t   evict_line_i;
  logic    biu_stb_ack_i, biu_d_ack_i, biu_ack_i, biu_err_i;
  logic    biucmd_ack_o, biucmd_busy_o, nc_ack_o, in_linebuf_o, biu_line_dirty_o;
  logic    biu_stb_o, biu_we_o;
  addr_t   biu_adr_o;
  word_t   biu_d_o;
  line_t   biu_line_o;
  inflight_t   inflight_o;
  burst_type_e biu_type_o;

  // stimulus table, one row per test
  string      t_name  [NUM_TESTS];
  test_kind_e t_kind  [NUM_TESTS];
  addr_t      t_adr   [NUM_TESTS];
  be_t        t_be    [NUM_TESTS];
  word_t      t_d     [NUM_TESTS];
  int         t_stall [NUM_TESTS];

  int    err_cnt;
  int    test_errs;
  string cur_name;

  cache_biu_ctrl DUT (.*);

  always #2 clk_i = ~clk_i;  // 4 ns period

  function automatic word_t lcg_step(input word_t x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory contents of the BIU model
  function automatic word_t model_word(input addr_t adr);
    return lcg_step(SEED ^ adr);
  endfunction

  function automatic word_t byte_mask(input be_t be);
    word_t m;
    for (int i = 0; i < 4; i++)
      m[8*i +: 8] = {8{be[i]}};
    return m;
  endfunction

  task automatic set_entry(input int i, input string n, input test_kind_e k, input addr_t a,
                           input be_t b, input word_t d, input int s);
    t_name[i]  = n;
    t_kind[i]  = k;
    t_adr[i]   = a;
    t_be[i]    = b;
    t_d[i]     = d;
    t_stall[i] = s;
  endtask

  task automatic compare_val(input string what, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("Error %s %s expected %0h actual %0h", cur_name, what, exp_v, act_v);
      err_cnt++;
      test_errs++;
    end
  endtask

  ////////////////////
  // BIU model
  ////////////////////
  // hold off the strobe for stall cycles, then accept it for one cycle
  task automatic accept_strobe(input int stall, input addr_t exp_adr, input logic burst,
                               input logic wr);
    for (int i = 0; i < stall; i++)
    begin
      @(posedge clk_i);
      @(negedge clk_i);
      compare_val("biu_stb_o held", 1, biu_stb_o);
      compare_val("biu_adr_o held", exp_adr, biu_adr_o);
      compare_val("biucmd_busy_o in wait", burst, biucmd_busy_o);
    end
    @(posedge clk_i);
    biu_stb_ack_i <= 1'b1;
    biu_d_ack_i   <= wr;  // word 0 leaves with the strobe
    @(negedge clk_i);
    compare_val("biu_stb_o at accept", 1, biu_stb_o);
  endtask

  task automatic end_burst();
    @(posedge clk_i);
    biucmd_i    <= CMD_NOP;
    biu_ack_i   <= 1'b0;
    biu_d_ack_i <= 1'b0;
    we_i        <= 1'b0;
    be_i        <= '0;
    @(negedge clk_i);
    compare_val("biucmd_busy_o after ack", 0, biucmd_busy_o);
    compare_val("biu_stb_o idle", 0, biu_stb_o);
    compare_val("inflight_o drained", 0, inflight_o);
  endtask

  task automatic run_fill(input addr_t adr, input be_t be, input word_t d, input int stall,
                          input logic store);
    addr_t base;
    addr_t beat_adr;
    line_t exp_line;
    word_t w;
    int    idx;
    base = {adr[31:4], 4'h0};
    idx  = int'(adr[3:2]);
    for (int i = 0; i < `CB_BURST_LEN; i++)
    begin
      w = model_word(base + addr_t'(4 * i));
      if (store && idx == i)
        w = (w & ~byte_mask(be)) | (d & byte_mask(be));  // store bytes win
      exp_line[32*i +: 32] = w;
    end
    @(posedge clk_i);
    biucmd_i <= CMD_READWAY;
    adr_i    <= adr;
    we_i     <= store;
    be_i     <= be;
    d_i      <= d;
    @(negedge clk_i);
    compare_val("biu_stb_o", 1, biu_stb_o);
    compare_val("biu_type_o", BT_WRAP4, biu_type_o);
    compare_val("biu_adr_o", {adr[31:2], 2'b00}, biu_adr_o);
    compare_val("biu_we_o", 0, biu_we_o);
    compare_val("biucmd_busy_o at command", 0, biucmd_busy_o);
    accept_strobe(stall, {adr[31:2], 2'b00}, 1'b1, 1'b0);
    for (int j = 0; j < `CB_BURST_LEN; j++)
    begin
      beat_adr = base + addr_t'(4 * ((idx + j) % 4));  // wrap from requested word
      @(posedge clk_i);
      biu_stb_ack_i <= 1'b0;
      biu_ack_i     <= 1'b1;
      biu_adro_i    <= beat_adr;
      biu_q_i       <= model_word(beat_adr);
      @(negedge clk_i);
      compare_val("biucmd_ack_o", j == 3, biucmd_ack_o);
      compare_val("biucmd_busy_o in burst", 1, biucmd_busy_o);
      if (j == 0)
        compare_val("inflight_o", 4, inflight_o);
    end
    compare_val("biu_line_o", exp_line, biu_line_o);
    compare_val("biu_line_dirty_o", store, biu_line_dirty_o);
    compare_val("in_linebuf_o", 1, in_linebuf_o);
    end_burst();
  endtask

  task automatic run_writeback(input addr_t adr, input word_t pat, input int stall);
    line_t line;
    for (int i = 0; i < `CB_BURST_LEN; i++)
      line[32*i +: 32] = model_word(adr + addr_t'(4 * i)) ^ pat;
    @(posedge clk_i);
    biucmd_i     <= CMD_WRITEWAY;
    evict_adr_i  <= adr;
    evict_line_i <= line;
    @(negedge clk_i);
    compare_val("biu_stb_o", 1, biu_stb_o);
    compare_val("biu_type_o", BT_WRAP4, biu_type_o);
    compare_val("biu_adr_o", adr, biu_adr_o);
    compare_val("biu_we_o", 1, biu_we_o);
    accept_strobe(stall, adr, 1'b1, 1'b1);
    compare_val("biu_d_o word 0", line[31:0], biu_d_o);
    compare_val("biu_we_o at accept", 1, biu_we_o);
    for (int j = 0; j < `CB_BURST_LEN; j++)
    begin
      @(posedge clk_i);
      biu_stb_ack_i <= 1'b0;
      biu_ack_i     <= 1'b1;
      biu_adro_i    <= adr + addr_t'(4 * j);
      biu_d_ack_i   <= (j < 3);  // last three words
      @(negedge clk_i);
      if (j < 3)
        compare_val($sformatf("biu_d_o word %0d", j + 1), line[32*(j+1) +: 32], biu_d_o);
      compare_val("biucmd_ack_o", j == 3, biucmd_ack_o);
    end
    end_burst();
  endtask

  // single transfer, flush raised while its beat is outstanding
  task automatic run_noncache(input addr_t adr, input int stall, input logic flush);
    @(posedge clk_i);
    biucmd_i <= CMD_NOP;
    nc_req_i <= 1'b1;
    adr_i    <= adr;
    we_i     <= 1'b0;
    @(negedge clk_i);
    compare_val("biu_stb_o", 1, biu_stb_o);
    compare_val("biu_type_o", BT_INCR, biu_type_o);
    compare_val("biu_adr_o", adr, biu_adr_o);
    accept_strobe(stall, adr, 1'b0, 1'b0);
    @(posedge clk_i);
    biu_stb_ack_i <= 1'b0;
    nc_req_i      <= 1'b0;
    flush_i       <= flush;
    @(negedge clk_i);
    compare_val("inflight_o outstanding", 1, inflight_o);
    @(posedge clk_i);
    flush_i    <= 1'b0;
    biu_ack_i  <= 1'b1;
    biu_adro_i <= adr;
    biu_q_i    <= model_word(adr);
    @(negedge clk_i);
    compare_val("nc_ack_o", !flush, nc_ack_o);
    @(posedge clk_i);
    biu_ack_i <= 1'b0;
    @(negedge clk_i);
    compare_val("inflight_o drained", 0, inflight_o);
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial
  begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    biucmd_i      = CMD_NOP;
    nc_req_i      = 1'b0;
    flush_i       = 1'b0;
    we_i          = 1'b0;
    adr_i         = '0;
    evict_adr_i   = '0;
    be_i          = '0;
    d_i           = '0;
    evict_line_i  = '0;
    biu_adro_i    = '0;
    biu_q_i       = '0;
    biu_stb_ack_i = 1'b0;
    biu_d_ack_i   = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    err_cnt       = 0;
    set_entry(0, "fill_word0", T_FILL, 32'h0000_1000, 4'h0, 32'h0, 0);
    set_entry(1, "fill_wrap_stall", T_FILL, 32'h0000_204a, 4'h0, 32'h0, 3);
    set_entry(2, "fill_store_half", T_FILL_STORE, 32'h0000_3014, 4'b0101, 32'hdead_beef, 1);
    set_entry(3, "fill_store_word", T_FILL_STORE, 32'h0000_401c, 4'hf, 32'h1234_5678, 0);
    set_entry(4, "writeback", T_WRITEBACK, 32'h0000_5000, 4'h0, 32'h0f0f_0f0f, 0);
    set_entry(5, "writeback_stall", T_WRITEBACK, 32'h0000_6010, 4'h0, 32'ha5a5_5a5a, 4);
    set_entry(6, "noncache", T_NONCACHE, 32'h8000_0006, 4'h0, 32'h0, 0);
    set_entry(7, "noncache_stall", T_NONCACHE, 32'h8000_0104, 4'h0, 32'h0, 2);
    set_entry(8, "flush_discard", T_FLUSH, 32'h8000_0200, 4'h0, 32'h0, 1);

    // outputs settle low while reset is held
    cur_name  = "reset";
    test_errs = 0;
    repeat (15) @(posedge clk_i);
    @(negedge clk_i);
    compare_val("biu_stb_o", 0, biu_stb_o);
    compare_val("biucmd_ack_o", 0, biucmd_ack_o);
    compare_val("biucmd_busy_o", 0, biucmd_busy_o);
    compare_val("nc_ack_o", 0, nc_ack_o);
    compare_val("inflight_o", 0, inflight_o);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int t = 0; t < NUM_TESTS; t++)
    begin
      cur_name  = t_name[t];
      test_errs = 0;
      case (t_kind[t])
        T_FILL:       run_fill(t_adr[t], t_be[t], t_d[t], t_stall[t], 1'b0);
        T_FILL_STORE: run_fill(t_adr[t], t_be[t], t_d[t], t_stall[t], 1'b1);
        T_WRITEBACK:  run_writeback(t_adr[t], t_d[t], t_stall[t]);
        T_NONCACHE:   run_noncache(t_adr[t], t_stall[t], 1'b0);
        default:
        begin
          run_noncache(t_adr[t], t_stall[t], 1'b1);
          run_noncache(t_adr[t] + 32'h4, 0, 1'b0);  // next one acked again
        end
      endcase
      if (test_errs == 0)
        $display("test %s done, ok", cur_name);
      else
        $display("test %s done, %0d mismatches", cur_name, test_errs);
    end

    $display("%0d tests run, %0d errors", NUM_TESTS, err_cnt);
    if (err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // watchdog, 64 cycles per test plus margin
  initial
  begin
    #(WD_CYCLES * 4);
    $display("watchdog expired, a test did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+design
design/cache_biu_pkg.sv
design/biu_burst_fsm.sv
design/biu_line_buffer.sv
design/biu_inflight_tracker.sv
design/cache_biu_ctrl.sv
tests/cache_biu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it into sim.log, then look for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cache_biu_tb \
  -o sim_tb || echo "Simulation FAILED" > sim.log
[ -x obj_dir/sim_tb ] && ./obj_dir/sim_tb >> sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log
! grep -q "Simulation FAILED" sim.log
